/* project.f */
+incdir+testbench
common/mandel_pkg.sv
common/job_if.sv
common/result_if.sv
iterator/escape_iterator.sv
src/pixel_dispatcher.sv
src/pixel_writer.sv
src/mandel_top.sv
testbench/tb_mandel.sv

/* testbench/mandel_model.svh */
`ifndef MANDEL_MODEL_SVH
`define MANDEL_MODEL_SVH

////////////////////////////////////////
// Fixed-point iteration
////////////////////////////////////////

// Full 54-bit product, sign kept plus bits 48 down to 23
function automatic fix_t model_mul(fix_t a, fix_t b);
	logic signed [53:0] wa;
	logic signed [53:0] wb;
	logic signed [53:0] wide;
	wa = a;
	wb = b;
	wide = wa * wb;
	return {wide[53], wide[48:23]};
endfunction

// Iterations until escape, the escaping one counted
function automatic int model_count(fix_t cr, fix_t ci, int limit);
	fix_t zr;
	fix_t zi;
	fix_t rr;
	fix_t ii;
	fix_t ri;
	fix_t nr;
	fix_t ni;
	fix_t mag;
	fix_t lo;
	zr = '0;
	zi = '0;
	lo = -ESC_COORD;
	for (int n = 1; n <= limit; n++) begin
		rr = model_mul(zr, zr);
		ii = model_mul(zi, zi);
		ri = model_mul(zr, zi);
		// Sums wrap at 27 bits like the hardware adders
		nr = rr - ii + cr;
		ni = ri + ri + ci;
		mag = rr + ii;
		if (mag > ESC_MAG_SQ || nr > ESC_COORD || nr < lo
			|| ni > ESC_COORD || ni < lo || n == limit) begin
			return n;
		end
		zr = nr;
		zi = ni;
	end
	return limit;
endfunction

////////////////////////////////////////
// Colour and coordinates
////////////////////////////////////////

// Descending thresholds, limit >> 2 down to limit >> 7
function automatic color_t model_colour(int count, int limit);
	if (count >= limit) return 8'b000_000_00;
	if (count >= (limit >> 2)) return 8'b011_001_00;
	if (count >= (limit >> 3)) return 8'b101_010_01;
	if (count >= (limit >> 4)) return 8'b011_001_01;
	if (count >= (limit >> 5)) return 8'b001_001_01;
	if (count >= (limit >> 6)) return 8'b011_010_10;
	return 8'b010_100_10;
endfunction

// Real part grows left to right
function automatic fix_t pixel_re(fix_t origin, logic [4:0] zm, int col);
	fix_t step;
	step = STEP_BASE >>> zm;
	return origin + fix_t'(col * step);
endfunction

// Imaginary part falls row by row
function automatic fix_t pixel_im(fix_t origin, logic [4:0] zm, int row);
	fix_t step;
	step = STEP_BASE >>> zm;
	return origin - fix_t'(row * step);
endfunction

`endif

/* testbench/tb_mandel.sv */
`timescale 1ns/1ps

module tb_mandel
	import mandel_pkg::*;
();

	localparam int X_PIX = 16;
	localparam int Y_PIX = 8;
	localparam int PIXELS = X_PIX * Y_PIX;
	localparam int NUM_IT = 4;
	localparam int LIMIT = 64;
	localparam int FRAMES = 7;
	localparam int CYCLE_LIMIT = FRAMES * PIXELS * (LIMIT + 4) + 200;
	localparam fix_t ONE = fix_t'(1 << FIX_FRAC);
	localparam fix_t TWO = fix_t'(2 << FIX_FRAC);
	localparam color_t BLACK = 8'b000_000_00;
	// Count of 2 lands between limit >> 5 and limit >> 4
	localparam color_t EDGE_COLOUR = 8'b001_001_01;

	logic clk;
	logic reset;
	logic start;
	fix_t x_start;
	fix_t y_start;
	logic [4:0] zoom;
	logic mem_we;
	addr_t mem_addr;
	color_t mem_data;
	logic busy;
	logic done;

	logic [31:0] lfsr = 32'h1e3ae821;
	int cycles = 0;

	`include "mandel_model.svh"

	mandel_top #(
		.NUM_ITER(NUM_IT),
		.X_PIXELS(X_PIX),
		.Y_PIXELS(Y_PIX),
		.ITER_MAX(LIMIT)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.x_start(x_start),
		.y_start(y_start),
		.zoom(zoom),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.busy(busy),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] galois_step(logic [31:0] s);
		// Taps for x^32 + x^22 + x^2 + x + 1
		return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	// One LFSR step per bit with the first bit on top
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = galois_step(lfsr);
		end
	endtask

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_write(input addr_t addr, input color_t got, input color_t want);
		if (got !== want) begin
			report_failure($sformatf("mismatch mem_data at mem_addr %h: got %h, expected %h",
				addr, got, want));
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, want));
		end
	endtask

	// Run limit scales with frame count and worst case per pixel
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			report_failure($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
		end
	end

	////////////////////////////////////////
	// One frame from start to done
	////////////////////////////////////////
	task automatic run_frame(input fix_t xs, input fix_t ys, input logic [4:0] zm,
		input bit poke, input bit dark, input bit edge_col);
		color_t want [PIXELS];
		bit seen [PIXELS];
		int writes;
		int a;
		logic [31:0] junk;
		for (a = 0; a < PIXELS; a++) begin
			want[a] = model_colour(model_count(pixel_re(xs, zm, a % X_PIX),
				pixel_im(ys, zm, a / X_PIX), LIMIT), LIMIT);
			seen[a] = 1'b0;
		end
		@(posedge clk);
		start <= 1'b1;
		x_start <= xs;
		y_start <= ys;
		zoom <= zm;
		@(posedge clk);
		start <= 1'b0;
		// Pan inputs wander once the start cycle is over
		take_bits(27, junk);
		x_start <= fix_t'(junk);
		take_bits(27, junk);
		y_start <= fix_t'(junk);
		take_bits(5, junk);
		zoom <= junk[4:0];
		writes = 0;
		fork
			begin
				// Second start in mid frame is ignored
				if (poke) begin
					repeat (3) @(posedge clk);
					start <= 1'b1;
					@(posedge clk);
					start <= 1'b0;
				end
			end
			begin
				while (writes < PIXELS) begin
					@(negedge clk);
					compare_flag("busy", busy, 1'b1);
					compare_flag("done", done, 1'b0);
					if ($isunknown(mem_we)) begin
						report_failure("write strobe is unknown during the frame");
					end
					if (mem_we) begin
						if ($isunknown(mem_addr) || mem_addr >= addr_t'(PIXELS)) begin
							report_failure($sformatf("write address %h lies outside the frame",
								mem_addr));
						end
						a = int'(mem_addr);
						if (seen[a]) begin
							report_failure($sformatf("address %0d written twice", a));
						end
						seen[a] = 1'b1;
						compare_write(mem_addr, mem_data, want[a]);
						if (dark) begin
							compare_write(mem_addr, mem_data, BLACK);
						end
						if (edge_col && (a % X_PIX) == 0) begin
							compare_write(mem_addr, mem_data, EDGE_COLOUR);
						end
						writes++;
					end
				end
			end
		join
		// One cycle after the last strobe
		@(negedge clk);
		compare_flag("done", done, 1'b1);
		compare_flag("busy", busy, 1'b0);
		compare_flag("mem_we", mem_we, 1'b0);
		for (a = 0; a < PIXELS; a++) begin
			if (!seen[a]) begin
				report_failure($sformatf("address %0d never written", a));
			end
		end
		// done holds while idle
		repeat (3) begin
			@(negedge clk);
			compare_flag("done", done, 1'b1);
			compare_flag("busy", busy, 1'b0);
			compare_flag("mem_we", mem_we, 1'b0);
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		logic [31:0] r;
		fix_t xs;
		fix_t ys;
		logic [4:0] zm;
		reset = 1'b1;
		start = 1'b0;
		x_start = '0;
		y_start = '0;
		zoom = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		// Quiet outputs before any start
		repeat (20) begin
			@(negedge clk);
			compare_flag("mem_we", mem_we, 1'b0);
			compare_flag("busy", busy, 1'b0);
			compare_flag("done", done, 1'b0);
		end
		// Random pan over -2..1 and -1..1 with a stray start in the last frame
		for (int f = 0; f < 5; f++) begin
			take_bits(25, r);
			xs = fix_t'(r % (3 << FIX_FRAC)) - TWO;
			take_bits(24, r);
			ys = fix_t'(r[23:0]) - ONE;
			take_bits(2, r);
			zm = {3'b000, r[1:0]};
			run_frame(xs, ys, zm, f == 4, 1'b0, 1'b0);
		end
		// Deep inside the main cardioid
		run_frame(fix_t'(-838861), fix_t'(419430), 5'd3, 1'b0, 1'b1, 1'b0);
		// Left edge at -2 with an imaginary part near 1
		run_frame(-TWO, ONE, 5'd0, 1'b0, 1'b0, 1'b1);
		$display("Verification passed");
		$finish;
	end

endmodule

/* src/mandel_top.sv */
`timescale 1ns/1ps

module mandel_top
	import mandel_pkg::*;
#(
	parameter int NUM_ITER = 4,
	parameter int X_PIXELS = 640,
	parameter int Y_PIXELS = 480,
	parameter int ITER_MAX = 1000
) (
	input logic clk,
	input logic reset,
	input logic start,
	input fix_t x_start,
	input fix_t y_start,
	input logic [4:0] zoom,
	output logic mem_we,
	output addr_t mem_addr,
	output color_t mem_data,
	output logic busy,
	output logic done
);

	// Last write seen, ends the frame in the dispatcher
	logic frame_done;

	// One job link and one result link per iterator
	job_if jobs [NUM_ITER] ();
	result_if results [NUM_ITER] ();

	////////////////////////////////////////
	// Frame sequencer
	////////////////////////////////////////
	pixel_dispatcher #(
		.NUM_ITER(NUM_ITER),
		.X_PIXELS(X_PIXELS),
		.Y_PIXELS(Y_PIXELS)
	) dispatcher_u (
		.clk(clk),
		.reset(reset),
		.start(start),
		.x_start(x_start),
		.y_start(y_start),
		.zoom(zoom),
		.frame_done(frame_done),
		.busy(busy),
		.jobs(jobs)
	);

	// Row of escape-time units
	for (genvar i = 0; i < NUM_ITER; i++) begin : g_iter
		escape_iterator #(
			.ITER_MAX(ITER_MAX)
		) iterator_u (
			.clk(clk),
			.reset(reset),
			.job(jobs[i]),
			.result(results[i])
		);
	end

	////////////////////////////////////////
	// Result drain and write port
	////////////////////////////////////////
	pixel_writer #(
		.NUM_ITER(NUM_ITER),
		.X_PIXELS(X_PIXELS),
		.Y_PIXELS(Y_PIXELS),
		.ITER_MAX(ITER_MAX)
	) writer_u (
		.clk(clk),
		.reset(reset),
		.start(start),
		.results(results),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.frame_done(frame_done),
		.done(done)
	);

endmodule

/* src/pixel_writer.sv */
`timescale 1ns/1ps

module pixel_writer
	import mandel_pkg::*;
#(
	parameter int NUM_ITER = 4,
	parameter int X_PIXELS = 640,
	parameter int Y_PIXELS = 480,
	parameter int ITER_MAX = 1000
) (
	input logic clk,
	input logic reset,
	input logic start,
	result_if.writer results [NUM_ITER],
	output logic mem_we,
	output addr_t mem_addr,
	output color_t mem_data,
	output logic frame_done,
	output logic done
);

	localparam int TOTAL = X_PIXELS * Y_PIXELS;
	localparam int CW = $clog2(TOTAL + 1);
	localparam int PTR_W = (NUM_ITER > 1) ? $clog2(NUM_ITER) : 1;

	logic [NUM_ITER-1:0] valid_vec;
	iter_t count_arr [NUM_ITER];
	addr_t addr_arr [NUM_ITER];
	logic [PTR_W-1:0] last_grant;
	logic [PTR_W-1:0] grant_idx;
	logic grant_any;
	// Writes issued in this frame
	logic [CW-1:0] wr_cnt;
	// Tracks the dispatcher's busy window
	logic frame_active;

	for (genvar i = 0; i < NUM_ITER; i++) begin : g_res
		assign valid_vec[i] = results[i].res_valid;
		assign count_arr[i] = results[i].count;
		assign addr_arr[i] = results[i].addr;
		// Taken in the grant cycle itself
		assign results[i].res_ready = grant_any && (grant_idx == PTR_W'(i));
	end

	////////////////////////////////////////
	// Round-robin pick
	////////////////////////////////////////
	always_comb begin
		int idx;
		grant_any = 1'b0;
		grant_idx = last_grant;
		// Walk backwards so the nearest one after last_grant wins
		for (int k = NUM_ITER; k >= 1; k--) begin
			idx = (int'(last_grant) + k) % NUM_ITER;
			if (valid_vec[idx]) begin
				grant_any = 1'b1;
				grant_idx = PTR_W'(idx);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_we <= 1'b0;
			frame_done <= 1'b0;
			done <= 1'b0;
			frame_active <= 1'b0;
			last_grant <= '0;
			wr_cnt <= '0;
		end else begin
			mem_we <= grant_any;
			// Pulse lines up with the final strobe
			frame_done <= grant_any && (wr_cnt == CW'(TOTAL - 1));
			if (grant_any) begin
				last_grant <= grant_idx;
				wr_cnt <= wr_cnt + 1'b1;
			end
			if (start && !frame_active) begin
				frame_active <= 1'b1;
				done <= 1'b0;
				wr_cnt <= '0;
			end else if (frame_done) begin
				frame_active <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// Write payload, one cycle behind the grant
	always_ff @(posedge clk) begin
		mem_addr <= addr_arr[grant_idx];
		mem_data <= color_for(count_arr[grant_idx], iter_t'(ITER_MAX));
	end

endmodule

/* src/pixel_dispatcher.sv */
`timescale 1ns/1ps

module pixel_dispatcher
	import mandel_pkg::*;
#(
	parameter int NUM_ITER = 4,
	parameter int X_PIXELS = 640,
	parameter int Y_PIXELS = 480
) (
	input logic clk,
	input logic reset,
	input logic start,
	input fix_t x_start,
	input fix_t y_start,
	input logic [4:0] zoom,
	input logic frame_done,
	output logic busy,
	job_if.dispatcher jobs [NUM_ITER]
);

	localparam int PTR_W = (NUM_ITER > 1) ? $clog2(NUM_ITER) : 1;
	localparam int XW = $clog2(X_PIXELS + 1);
	localparam int YW = $clog2(Y_PIXELS + 1);

	// Pixels left to hand out
	logic issuing;
	// Iterator currently offered the job
	logic [PTR_W-1:0] ptr;
	logic [XW-1:0] x_cnt;
	logic [YW-1:0] y_cnt;
	// Row origin and step latched at start
	fix_t x_origin;
	fix_t step;
	// Point of the pending pixel
	fix_t c_re;
	fix_t c_im;
	addr_t pix_addr;
	logic [NUM_ITER-1:0] ready_vec;
	logic launch;
	logic take;
	logic row_end;
	logic last_pixel;

	// Same job shown everywhere, valid only at the pointer
	for (genvar i = 0; i < NUM_ITER; i++) begin : g_job
		assign jobs[i].job_valid = issuing && (ptr == PTR_W'(i));
		assign jobs[i].c_re = c_re;
		assign jobs[i].c_im = c_im;
		assign jobs[i].addr = pix_addr;
		assign ready_vec[i] = jobs[i].job_ready;
	end

	// Start is dropped while a frame runs
	assign launch = start && !busy;
	assign take = issuing && ready_vec[ptr];
	assign row_end = (x_cnt == XW'(X_PIXELS - 1));
	assign last_pixel = row_end && (y_cnt == YW'(Y_PIXELS - 1));

	////////////////////////////////////////
	// Frame control
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			issuing <= 1'b0;
			ptr <= '0;
		end else if (launch) begin
			busy <= 1'b1;
			issuing <= 1'b1;
			ptr <= '0;
		end else begin
			// Held until the writer reports the last strobe
			if (frame_done) begin
				busy <= 1'b0;
			end
			if (take && last_pixel) begin
				issuing <= 1'b0;
			end
			// Rotate every cycle, taken or not
			if (issuing) begin
				ptr <= (ptr == PTR_W'(NUM_ITER - 1)) ? '0 : ptr + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Raster walk and coordinates
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (launch) begin
			x_origin <= x_start;
			// Each zoom level halves the step
			step <= STEP_BASE >>> zoom;
			c_re <= x_start;
			c_im <= y_start;
			x_cnt <= '0;
			y_cnt <= '0;
			pix_addr <= '0;
		end else if (take) begin
			pix_addr <= pix_addr + 1'b1;
			if (row_end) begin
				// New row, imaginary axis runs downward
				x_cnt <= '0;
				y_cnt <= y_cnt + 1'b1;
				c_re <= x_origin;
				c_im <= c_im - step;
			end else begin
				x_cnt <= x_cnt + 1'b1;
				c_re <= c_re + step;
			end
		end
	end

endmodule

/* iterator/escape_iterator.sv */
`timescale 1ns/1ps

module escape_iterator
	import mandel_pkg::*;
#(
	parameter int ITER_MAX = 1000
) (
	input logic clk,
	input logic reset,
	job_if.iterator job,
	result_if.iterator result
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CALC,
		ST_HOLD
	} state_t;

	state_t state;

	// Latched point and running z
	fix_t c_re;
	fix_t c_im;
	fix_t z_re;
	fix_t z_im;
	iter_t count;
	addr_t addr;

	// Products of the current z
	fix_t re_sq;
	fix_t im_sq;
	fix_t re_im;
	fix_t next_re;
	fix_t next_im;
	fix_t mag_sq;
	logic escape;

	// 4.23 product, sign kept plus bits 48 down to 23
	function automatic fix_t fix_mul(fix_t a, fix_t b);
		logic signed [2*FIX_W-1:0] p;
		p = a * b;
		return {p[2*FIX_W-1], p[FIX_FRAC+FIX_W-2:FIX_FRAC]};
	endfunction

	////////////////////////////////////////
	// One z^2 + c step per cycle
	////////////////////////////////////////
	assign re_sq = fix_mul(z_re, z_re);
	assign im_sq = fix_mul(z_im, z_im);
	assign re_im = fix_mul(z_re, z_im);

	assign next_re = re_sq - im_sq + c_re;
	// Doubling of re*im
	assign next_im = (re_im <<< 1) + c_im;
	assign mag_sq = re_sq + im_sq;

	// Radius test, coordinate box, or limit reached on this step
	assign escape = (mag_sq > ESC_MAG_SQ)
		|| (next_re > ESC_COORD) || (next_re < -ESC_COORD)
		|| (next_im > ESC_COORD) || (next_im < -ESC_COORD)
		|| (count == iter_t'(ITER_MAX - 1));

	// Handshakes come straight off the state
	assign job.job_ready = (state == ST_IDLE);
	assign result.res_valid = (state == ST_HOLD);
	assign result.count = count;
	assign result.addr = addr;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (job.job_valid) begin
						state <= ST_CALC;
					end
				end
				ST_CALC: begin
					if (escape) begin
						state <= ST_HOLD;
					end
				end
				ST_HOLD: begin
					// Free again once the writer takes the result
					if (result.res_ready) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			ST_IDLE: begin
				if (job.job_valid) begin
					c_re <= job.c_re;
					c_im <= job.c_im;
					addr <= job.addr;
					z_re <= '0;
					z_im <= '0;
					count <= '0;
				end
			end
			ST_CALC: begin
				z_re <= next_re;
				z_im <= next_im;
				// Ends up counting the escaping step too
				count <= count + 1'b1;
			end
			default: begin
				// z and count frozen while the result waits
			end
		endcase
	end

endmodule

/* common/result_if.sv */
`timescale 1ns/1ps

// One finished pixel, iterator to the writer
interface result_if
	import mandel_pkg::*;
();

	// Handshake, iterator holds until taken
	logic res_valid;
	logic res_ready;

	// Iterations performed, escaping one included
	iter_t count;

	// Address carried along from the job
	addr_t addr;

	modport iterator (
		output res_valid,
		output count,
		output addr,
		input res_ready
	);

	// Writer grants one ready per cycle
	modport writer (
		input res_valid,
		input count,
		input addr,
		output res_ready
	);

endinterface

/* common/job_if.sv */
`timescale 1ns/1ps

// One pixel job, dispatcher to a single iterator
interface job_if
	import mandel_pkg::*;
();

	// Handshake, transfer when both high
	logic job_valid;
	logic job_ready;

	// Complex point of the pixel
	fix_t c_re;
	fix_t c_im;

	// Frame buffer slot for the result
	addr_t addr;

	modport dispatcher (
		output job_valid,
		output c_re,
		output c_im,
		output addr,
		input job_ready
	);

	// Ready only while the iterator is idle
	modport iterator (
		input job_valid,
		input c_re,
		input c_im,
		input addr,
		output job_ready
	);

endinterface

/* common/mandel_pkg.sv */
package mandel_pkg;

	////////////////////////////////////////
	// Fixed point and widths
	////////////////////////////////////////

	// 4.23 signed, range just under +/-8.0
	localparam int FIX_W = 27;
	localparam int FIX_FRAC = 23;

	typedef logic signed [FIX_W-1:0] fix_t;

	// Count covers limits up to 2047
	typedef logic [10:0] iter_t;

	// 640x480 needs 19 address bits
	typedef logic [18:0] addr_t;

	// RGB332, red in the top three bits
	typedef logic [7:0] color_t;

	////////////////////////////////////////
	// Constants
	////////////////////////////////////////

	// 0.0046 * 2^23, unzoomed step between pixels
	localparam fix_t STEP_BASE = fix_t'(38587);

	// Escape radius on |z|^2 and on each coordinate
	localparam fix_t ESC_MAG_SQ = fix_t'(4 << FIX_FRAC);
	localparam fix_t ESC_COORD = fix_t'(2 << FIX_FRAC);

	// Inside the set
	localparam color_t COLOR_BLACK = 8'b000_000_00;

	// Entry i applies from limit >> (i + 2) upward
	localparam int COLOR_LEVELS = 6;
	localparam color_t COLOR_TABLE [0:COLOR_LEVELS-1] = '{
		8'b011_001_00,
		8'b101_010_01,
		8'b011_001_01,
		8'b001_001_01,
		8'b011_010_10,
		8'b010_100_10
	};

	// Highest threshold met wins, lowest entry also covers the tail
	function automatic color_t color_for(iter_t count, iter_t limit);
		color_t c;
		c = COLOR_TABLE[COLOR_LEVELS-1];
		for (int i = COLOR_LEVELS - 1; i >= 0; i--) begin
			if (count >= (limit >> (i + 2))) begin
				c = COLOR_TABLE[i];
			end
		end
		if (count >= limit) begin
			c = COLOR_BLACK;
		end
		return c;
	endfunction

endpackage
